//--- rtl/slm_pkg.sv
// shared widths, types, segment patterns and hex decoder for the slm control glue logic
package slm_pkg;

    // ====================
    // field widths
    // ====================
    localparam int SDRAM_ADDR_W   = 25;
    localparam int FRAME_ID_W     = 6;
    localparam int IMAGE_COUNT_W  = 7;
    localparam int CYCLES_W       = 16;
    localparam int GALVO_W        = 32;
    localparam int JTAG_STATE_W   = 7;
    localparam int SEGMENTS_W     = 7;
    localparam int SWITCHES_W     = 10;

    // word address on the shared sdram port
    typedef logic [SDRAM_ADDR_W-1:0]  sdram_addr_t;
    typedef logic [FRAME_ID_W-1:0]    frame_id_t;
    typedef logic [IMAGE_COUNT_W-1:0] image_count_t;
    typedef logic [CYCLES_W-1:0]      display_cycles_t;
    typedef logic [GALVO_W-1:0]       galvo_positions_t;
    typedef logic [JTAG_STATE_W-1:0]  jtag_state_t;
    // active low with segment a in bit 0 and segment g in bit 6
    typedef logic [SEGMENTS_W-1:0]    segments_t;
    typedef logic [7:0]               monitor_byte_t;
    typedef logic [SWITCHES_W-1:0]    switches_t;

    // ====================
    // opcodes and states
    // ====================
    // debug byte select taken from sw[7:0]
    typedef enum logic [7:0] {
        SEL_JTAG_STATES     = 8'd0,
        SEL_IMAGES_IN_MEM   = 8'd1,
        SEL_CYCLES_LOW      = 8'd2,
        SEL_CYCLES_HIGH     = 8'd3,
        SEL_GALVO_BYTE0     = 8'd4,
        SEL_GALVO_BYTE1     = 8'd5,
        SEL_GALVO_BYTE2     = 8'd6,
        SEL_GALVO_BYTE3     = 8'd7,
        SEL_SEQ_COUNT       = 8'd8,
        SEL_GALVO_SEQ_COUNT = 8'd9
    } monitor_select_e;

    // reset release order with one stage per step
    typedef enum logic [1:0] {
        STAGE_HOLD,
        STAGE_CORE,
        STAGE_WRITER,
        STAGE_RUNNING
    } reset_stage_e;

    // ====================
    // segment patterns
    // ====================
    localparam segments_t SEG_BLANK    = 7'b1111111;
    localparam segments_t SEG_LETTER_B = 7'b0000011;
    localparam segments_t SEG_LETTER_U = 7'b1000001;
    localparam segments_t SEG_LETTER_S = 7'b0010010;
    localparam segments_t SEG_LETTER_Y = 7'b0010001;

    // one nibble 0 to F to an active low digit
    function automatic segments_t hex_to_segments(input logic [3:0] digit);
        segments_t seg;
        case (digit)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0010000;
            4'ha: seg = 7'b0001000;
            4'hb: seg = 7'b0000011;
            4'hc: seg = 7'b1000110;
            4'hd: seg = 7'b0100001;
            4'he: seg = 7'b0000110;
            default: seg = 7'b0001110;
        endcase
        return seg;
    endfunction

endpackage

//--- rtl/slm_reset_sequencer.sv
// stretches the reset key into three reset stages released one step apart
`timescale 1ns/1ps

module slm_reset_sequencer #(
    parameter int unsigned STEP_CYCLES = 5_000_000
) (
    input  logic CLOCK_50,
    input  logic reset_key,
    output logic delayed_reset,
    output logic delayed_reset_1,
    output logic delayed_reset_2
);

    // step counter runs 0 .. STEP_CYCLES-1
    localparam int unsigned COUNT_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;
    localparam logic [COUNT_W-1:0] LAST_COUNT = COUNT_W'(STEP_CYCLES - 1);

    slm_pkg::reset_stage_e stage;
    slm_pkg::reset_stage_e next_stage;
    logic [COUNT_W-1:0]    step_count;
    logic                  step_done;

    // ====================
    // stage FSM
    // ====================
    assign step_done = (step_count == LAST_COUNT);

    // release order is core then writer then reader side
    always_comb begin
        case (stage)
            slm_pkg::STAGE_HOLD:   next_stage = slm_pkg::STAGE_CORE;
            slm_pkg::STAGE_CORE:   next_stage = slm_pkg::STAGE_WRITER;
            slm_pkg::STAGE_WRITER: next_stage = slm_pkg::STAGE_RUNNING;
            default:               next_stage = slm_pkg::STAGE_RUNNING;
        endcase
    end

    // key acts asynchronously while the release is synchronous
    always_ff @(posedge CLOCK_50 or posedge reset_key) begin
        if (reset_key) begin
            stage      <= slm_pkg::STAGE_HOLD;
            step_count <= '0;
        end else if (stage != slm_pkg::STAGE_RUNNING) begin
            if (step_done) begin
                // counter restarts for the next stage
                stage      <= next_stage;
                step_count <= '0;
            end else begin
                step_count <= step_count + 1'b1;
            end
        end
    end

    // ====================
    // stage outputs
    // ====================
    // each output stays high until its own stage is passed
    assign delayed_reset   = (stage == slm_pkg::STAGE_HOLD);
    assign delayed_reset_1 = (stage == slm_pkg::STAGE_HOLD) || (stage == slm_pkg::STAGE_CORE);
    assign delayed_reset_2 = (stage != slm_pkg::STAGE_RUNNING);

    // writer reset only drops once core reset was already low
    a_writer_after_core : assert property (
        @(posedge CLOCK_50) disable iff (reset_key)
        $fell(delayed_reset_1) |-> $past(!delayed_reset)
    );

    // reader stage only drops once writer reset was already low
    a_reader_after_writer : assert property (
        @(posedge CLOCK_50) disable iff (reset_key)
        $fell(delayed_reset_2) |-> $past(!delayed_reset_1)
    );

endmodule

//--- rtl/slm_sdram_access.sv
// shares the sdram command port between image writer and display reader and shows busy letters
`timescale 1ns/1ps

module slm_sdram_access (
    input  logic                CLOCK_50,
    input  logic                delayed_reset,
    input  logic                delayed_reset_2,
    input  logic                write_done,
    input  logic                write_request,
    input  logic                read_request,
    input  slm_pkg::sdram_addr_t write_address,
    input  slm_pkg::sdram_addr_t read_address,
    output slm_pkg::sdram_addr_t sdram_address,
    output logic                sdram_read_n,
    output logic                sdram_write_n,
    output logic                reader_reset,
    output slm_pkg::segments_t  hex5,
    output slm_pkg::segments_t  hex4,
    output slm_pkg::segments_t  hex3,
    output slm_pkg::segments_t  hex2
);

    // registered copy of the download-running level
    logic busy_q;

    // ====================
    // command port
    // ====================
    // writer owns the port until the download ends
    assign sdram_address = write_done ? read_address : write_address;

    // reads held off while the download runs
    assign sdram_read_n = ~(read_request & write_done);

    // writer request passes straight through
    assign sdram_write_n = ~write_request;

    // wait-request handling stays with the two masters
    // nothing is queued or held here

    // ====================
    // reader reset
    // ====================
    // reader stays in reset until the last stage and the download are both done
    assign reader_reset = delayed_reset_2 | ~write_done;

    // ====================
    // busy display
    // ====================
    // one cycle behind write_done
    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= ~write_done;
        end
    end

    // "bUSy" across the upper four digits
    assign hex5 = busy_q ? slm_pkg::SEG_LETTER_B : slm_pkg::SEG_BLANK;
    assign hex4 = busy_q ? slm_pkg::SEG_LETTER_U : slm_pkg::SEG_BLANK;
    assign hex3 = busy_q ? slm_pkg::SEG_LETTER_S : slm_pkg::SEG_BLANK;
    assign hex2 = busy_q ? slm_pkg::SEG_LETTER_Y : slm_pkg::SEG_BLANK;

    // read and write strobes never active in the same cycle
    a_no_read_write_overlap : assert property (
        @(posedge CLOCK_50) disable iff (delayed_reset)
        !(!sdram_read_n && !sdram_write_n)
    );

endmodule

//--- rtl/slm_panel_monitor.sv
// frame override, trigger counters and switch-selected debug byte on two hex digits
`timescale 1ns/1ps

module slm_panel_monitor (
    input  logic                      CLOCK_50,
    input  logic                      delayed_reset,
    input  slm_pkg::switches_t        sw,
    input  slm_pkg::frame_id_t        host_frame_id,
    input  slm_pkg::jtag_state_t      jtag_states,
    input  slm_pkg::image_count_t     images_in_mem,
    input  slm_pkg::display_cycles_t  display_cycles,
    input  slm_pkg::galvo_positions_t galvo_positions,
    input  logic                      sequencing_trigger,
    input  logic                      galvo_sequencing_trigger,
    output slm_pkg::frame_id_t        static_frame_id,
    output logic                      trigger_activity,
    output slm_pkg::segments_t        hex1,
    output slm_pkg::segments_t        hex0
);

    // trigger counters that wrap at 255
    logic [7:0] seq_count;
    logic [7:0] galvo_seq_count;

    slm_pkg::monitor_select_e monitor_select;
    slm_pkg::monitor_byte_t   monitor_byte;

    // ====================
    // frame override
    // ====================
    // sw[9] forces the frame from the low switches
    assign static_frame_id = sw[9] ? sw[5:0] : host_frame_id;

    // either trigger lights ledr8
    assign trigger_activity = sequencing_trigger | galvo_sequencing_trigger;

    // ====================
    // trigger counters
    // ====================
    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            seq_count       <= '0;
            galvo_seq_count <= '0;
        end else begin
            // one count per cycle the trigger is high
            if (sequencing_trigger) begin
                seq_count <= seq_count + 1'b1;
            end
            if (galvo_sequencing_trigger) begin
                galvo_seq_count <= galvo_seq_count + 1'b1;
            end
        end
    end

    // ====================
    // debug byte
    // ====================
    // low byte of the switches is the select opcode
    assign monitor_select = slm_pkg::monitor_select_e'(sw[7:0]);

    always_comb begin
        monitor_byte = '0;
        // sw[8] low keeps both digits at zero
        if (sw[8]) begin
            case (monitor_select)
                slm_pkg::SEL_JTAG_STATES:     monitor_byte = {1'b0, jtag_states};
                slm_pkg::SEL_IMAGES_IN_MEM:   monitor_byte = {1'b0, images_in_mem};
                slm_pkg::SEL_CYCLES_LOW:      monitor_byte = display_cycles[7:0];
                slm_pkg::SEL_CYCLES_HIGH:     monitor_byte = display_cycles[15:8];
                // galvo count one byte at a time
                slm_pkg::SEL_GALVO_BYTE0:     monitor_byte = galvo_positions[7:0];
                slm_pkg::SEL_GALVO_BYTE1:     monitor_byte = galvo_positions[15:8];
                slm_pkg::SEL_GALVO_BYTE2:     monitor_byte = galvo_positions[23:16];
                slm_pkg::SEL_GALVO_BYTE3:     monitor_byte = galvo_positions[31:24];
                slm_pkg::SEL_SEQ_COUNT:       monitor_byte = seq_count;
                slm_pkg::SEL_GALVO_SEQ_COUNT: monitor_byte = galvo_seq_count;
                // unknown opcodes show zero
                default:                      monitor_byte = '0;
            endcase
        end
    end

    // upper nibble on the left digit and lower nibble on the right
    assign hex1 = slm_pkg::hex_to_segments(monitor_byte[7:4]);
    assign hex0 = slm_pkg::hex_to_segments(monitor_byte[3:0]);

    // counters only move on a cycle with their trigger
    a_seq_count_hold : assert property (
        @(posedge CLOCK_50) disable iff (delayed_reset)
        !sequencing_trigger |=> $stable(seq_count)
    );

    a_galvo_count_hold : assert property (
        @(posedge CLOCK_50) disable iff (delayed_reset)
        !galvo_sequencing_trigger |=> $stable(galvo_seq_count)
    );

endmodule

//--- rtl/slm_control_top.sv
// top level of the slm control glue with reset stages, sdram port sharing and panel display
`timescale 1ns/1ps

module slm_control_top #(
    parameter int unsigned STEP_CYCLES = 5_000_000
) (
    input  logic                      CLOCK_50,
    input  logic                      reset_key,
    output logic                      core_reset,
    output logic                      writer_reset,

    // sdram masters and shared command port
    input  logic                      write_done,
    input  logic                      write_request,
    input  logic                      read_request,
    input  slm_pkg::sdram_addr_t      write_address,
    input  slm_pkg::sdram_addr_t      read_address,
    output slm_pkg::sdram_addr_t      sdram_address,
    output logic                      sdram_read_n,
    output logic                      sdram_write_n,
    output logic                      reader_reset,

    // host decoder values and panel
    input  slm_pkg::switches_t        sw,
    input  slm_pkg::frame_id_t        host_frame_id,
    input  slm_pkg::jtag_state_t      jtag_states,
    input  slm_pkg::image_count_t     images_in_mem,
    input  slm_pkg::display_cycles_t  display_cycles,
    input  slm_pkg::galvo_positions_t galvo_positions,
    input  logic                      sequencing_trigger,
    input  logic                      galvo_sequencing_trigger,
    output slm_pkg::frame_id_t        static_frame_id,
    output logic                      ledr8,
    output slm_pkg::segments_t        hex5,
    output slm_pkg::segments_t        hex4,
    output slm_pkg::segments_t        hex3,
    output slm_pkg::segments_t        hex2,
    output slm_pkg::segments_t        hex1,
    output slm_pkg::segments_t        hex0
);

    // staged resets
    logic delayed_reset;
    logic delayed_reset_2;

    // core reset also leaves the chip
    assign core_reset = delayed_reset;

    // ====================
    // reset stages
    // ====================
    slm_reset_sequencer #(
        .STEP_CYCLES     (STEP_CYCLES)
    ) u_reset_sequencer (
        .CLOCK_50        (CLOCK_50),
        .reset_key       (reset_key),
        .delayed_reset   (delayed_reset),
        .delayed_reset_1 (writer_reset),
        .delayed_reset_2 (delayed_reset_2)
    );

    // ====================
    // sdram port
    // ====================
    slm_sdram_access u_sdram_access (
        .CLOCK_50        (CLOCK_50),
        .delayed_reset   (delayed_reset),
        .delayed_reset_2 (delayed_reset_2),
        .write_done      (write_done),
        .write_request   (write_request),
        .read_request    (read_request),
        .write_address   (write_address),
        .read_address    (read_address),
        .sdram_address   (sdram_address),
        .sdram_read_n    (sdram_read_n),
        .sdram_write_n   (sdram_write_n),
        .reader_reset    (reader_reset),
        .hex5            (hex5),
        .hex4            (hex4),
        .hex3            (hex3),
        .hex2            (hex2)
    );

    // ====================
    // panel monitor
    // ====================
    slm_panel_monitor u_panel_monitor (
        .CLOCK_50                 (CLOCK_50),
        .delayed_reset            (delayed_reset),
        .sw                       (sw),
        .host_frame_id            (host_frame_id),
        .jtag_states              (jtag_states),
        .images_in_mem            (images_in_mem),
        .display_cycles           (display_cycles),
        .galvo_positions          (galvo_positions),
        .sequencing_trigger       (sequencing_trigger),
        .galvo_sequencing_trigger (galvo_sequencing_trigger),
        .static_frame_id          (static_frame_id),
        .trigger_activity         (ledr8),
        .hex1                     (hex1),
        .hex0                     (hex0)
    );

endmodule

//--- verification/tb_slm_control_top.sv
// self-checking testbench for slm_control_top that runs the reset check and then the stimulus table
`timescale 1ns/1ps

module tb_slm_control_top;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int SETTLE_DELAY = 40;
    localparam int RESET_CYCLES = 8;
    localparam int STEP_CYCLES  = 4;
    localparam int NUM_ROWS     = 16;
    localparam int SEED         = 19516;

    // active low digit patterns 0 to F with segment a in bit 0
    localparam slm_pkg::segments_t DIGIT_SEGMENTS [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    // one table row with stimulus then expected values
    typedef struct {
        slm_pkg::switches_t sw_value;
        slm_pkg::frame_id_t host_id;
        logic               write_done;
        logic               write_request;
        logic               read_request;
        int                 seq_pulses;
        int                 galvo_pulses;
        slm_pkg::frame_id_t exp_frame_id;
        logic               exp_busy;
    } row_t;

    logic CLOCK_50 = 1'b0;
    logic reset_key, core_reset, writer_reset;
    logic write_done, write_request, read_request;
    logic sdram_read_n, sdram_write_n, reader_reset;
    logic sequencing_trigger, galvo_sequencing_trigger, ledr8;
    slm_pkg::sdram_addr_t      write_address, read_address, sdram_address;
    slm_pkg::switches_t        sw;
    slm_pkg::frame_id_t        host_frame_id, static_frame_id;
    slm_pkg::jtag_state_t      jtag_states;
    slm_pkg::image_count_t     images_in_mem;
    slm_pkg::display_cycles_t  display_cycles;
    slm_pkg::galvo_positions_t galvo_positions;
    slm_pkg::segments_t        hex5, hex4, hex3, hex2, hex1, hex0;

    row_t  rows [NUM_ROWS];
    int    error_count = 0;
    int    errors_at_start = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    seq_total = 0;
    int    galvo_total = 0;
    logic  prev_done = 1'b0;
    string test_name;

    slm_control_top #(.STEP_CYCLES(STEP_CYCLES)) dut (.*);

    always #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;

    // ====================
    // compare tasks
    // ====================
    task automatic check_addr(input string name, input slm_pkg::sdram_addr_t got,
                              input slm_pkg::sdram_addr_t exp);
        if (got !== exp) begin
            $display("Error %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            error_count++;
        end
    endtask

    task automatic check_segments(input string name, input slm_pkg::segments_t got,
                                  input slm_pkg::segments_t exp);
        if (got !== exp) begin
            $display("Error %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            error_count++;
        end
    endtask

    task automatic check_frame(input string name, input slm_pkg::frame_id_t got,
                               input slm_pkg::frame_id_t exp);
        if (got !== exp) begin
            $display("Error %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            error_count++;
        end
    endtask

    // "bUSy" on the upper four digits or all blank
    task automatic check_busy_letters(input logic busy);
        check_segments("hex5", hex5, busy ? slm_pkg::SEG_LETTER_B : slm_pkg::SEG_BLANK);
        check_segments("hex4", hex4, busy ? slm_pkg::SEG_LETTER_U : slm_pkg::SEG_BLANK);
        check_segments("hex3", hex3, busy ? slm_pkg::SEG_LETTER_S : slm_pkg::SEG_BLANK);
        check_segments("hex2", hex2, busy ? slm_pkg::SEG_LETTER_Y : slm_pkg::SEG_BLANK);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = error_count;
    endtask

    task automatic finish_test();
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", test_name, error_count - errors_at_start);
        end
    endtask

    // ====================
    // reference model
    // ====================
    // debug byte from the switch opcode and the pulses applied so far
    function automatic slm_pkg::monitor_byte_t expected_byte(input slm_pkg::switches_t sw_value);
        slm_pkg::monitor_byte_t value;
        value = '0;
        if (sw_value[8]) begin
            case (sw_value[7:0])
                slm_pkg::SEL_JTAG_STATES:     value = {1'b0, jtag_states};
                slm_pkg::SEL_IMAGES_IN_MEM:   value = {1'b0, images_in_mem};
                slm_pkg::SEL_CYCLES_LOW:      value = display_cycles[7:0];
                slm_pkg::SEL_CYCLES_HIGH:     value = display_cycles[15:8];
                slm_pkg::SEL_GALVO_BYTE0:     value = galvo_positions[7:0];
                slm_pkg::SEL_GALVO_BYTE1:     value = galvo_positions[15:8];
                slm_pkg::SEL_GALVO_BYTE2:     value = galvo_positions[23:16];
                slm_pkg::SEL_GALVO_BYTE3:     value = galvo_positions[31:24];
                slm_pkg::SEL_SEQ_COUNT:       value = 8'(seq_total);
                slm_pkg::SEL_GALVO_SEQ_COUNT: value = 8'(galvo_total);
                default:                      value = '0;
            endcase
        end
        return value;
    endfunction

    task automatic set_row(input int idx, input slm_pkg::switches_t sw_value,
                           input slm_pkg::frame_id_t host_id, input logic done,
                           input logic wreq, input logic rreq, input int seq_p,
                           input int galvo_p, input slm_pkg::frame_id_t exp_frame,
                           input logic exp_busy);
        rows[idx] = '{sw_value, host_id, done, wreq, rreq, seq_p, galvo_p, exp_frame, exp_busy};
    endtask

    // ====================
    // stimulus table
    // ====================
    // sw, host id, done, wreq, rreq, seq pulses, galvo pulses, frame, busy
    task automatic fill_table();
        set_row(0,  10'h100, 6'h15, 1'b0, 1'b1, 1'b0, 2, 0, 6'h15, 1'b1);
        set_row(1,  10'h101, 6'h2a, 1'b0, 1'b1, 1'b1, 0, 3, 6'h2a, 1'b1);
        set_row(2,  10'h102, 6'h07, 1'b0, 1'b0, 1'b1, 1, 1, 6'h07, 1'b1);
        set_row(3,  10'h103, 6'h11, 1'b0, 1'b1, 1'b1, 0, 0, 6'h11, 1'b1);
        // override on so the frame comes from sw[5:0]
        set_row(4,  10'h308, 6'h3f, 1'b0, 1'b0, 1'b0, 1, 0, 6'h08, 1'b1);
        // download finishes here
        set_row(5,  10'h109, 6'h20, 1'b1, 1'b0, 1'b1, 3, 2, 6'h20, 1'b0);
        set_row(6,  10'h104, 6'h01, 1'b1, 1'b0, 1'b1, 0, 0, 6'h01, 1'b0);
        set_row(7,  10'h105, 6'h3e, 1'b1, 1'b1, 1'b0, 0, 0, 6'h3e, 1'b0);
        set_row(8,  10'h106, 6'h12, 1'b1, 1'b0, 1'b0, 0, 0, 6'h12, 1'b0);
        set_row(9,  10'h107, 6'h33, 1'b1, 1'b0, 1'b1, 0, 0, 6'h33, 1'b0);
        set_row(10, 10'h12a, 6'h0c, 1'b1, 1'b1, 1'b0, 0, 0, 6'h0c, 1'b0);
        // sw[8] low shows zero on both digits
        set_row(11, 10'h008, 6'h19, 1'b1, 1'b0, 1'b1, 4, 0, 6'h19, 1'b0);
        set_row(12, 10'h23c, 6'h05, 1'b1, 1'b0, 1'b0, 0, 1, 6'h3c, 1'b0);
        set_row(13, 10'h108, 6'h2d, 1'b1, 1'b1, 1'b0, 0, 0, 6'h2d, 1'b0);
        set_row(14, 10'h3ff, 6'h00, 1'b1, 1'b0, 1'b1, 2, 2, 6'h3f, 1'b0);
        set_row(15, 10'h109, 6'h1b, 1'b1, 1'b0, 1'b1, 5, 5, 6'h1b, 1'b0);
    endtask

    // stages fall STEP_CYCLES edges apart after the key is released
    task automatic check_reset_stages();
        logic done_now;
        logic exp_letters;
        start_test("reset stages");
        for (int edge_n = 1; edge_n <= 3 * STEP_CYCLES + 2; edge_n++) begin
            @(posedge CLOCK_50);
            #DRIVE_DELAY;
            // download ends while the reader stage is still held
            if (edge_n == 2 * STEP_CYCLES) begin
                write_done = 1'b1;
            end
            #SETTLE_DELAY;
            done_now = (edge_n >= 2 * STEP_CYCLES);
            // letters start one edge after core reset drops and clear one edge after done
            exp_letters = (edge_n > STEP_CYCLES) && (edge_n <= 2 * STEP_CYCLES);
            check_bit("core_reset", core_reset, edge_n < STEP_CYCLES);
            check_bit("writer_reset", writer_reset, edge_n < 2 * STEP_CYCLES);
            check_bit("reader_reset", reader_reset, !done_now || (edge_n < 3 * STEP_CYCLES));
            check_busy_letters(exp_letters);
        end
        prev_done = 1'b1;
        finish_test();
    endtask

    task automatic apply_row(input int r);
        slm_pkg::sdram_addr_t   wr_addr;
        slm_pkg::sdram_addr_t   rd_addr;
        slm_pkg::monitor_byte_t exp_byte;
        int                     pulses;
        wr_addr = slm_pkg::sdram_addr_t'($urandom());
        rd_addr = slm_pkg::sdram_addr_t'($urandom());
        pulses = (rows[r].seq_pulses > rows[r].galvo_pulses) ? rows[r].seq_pulses
                                                              : rows[r].galvo_pulses;
        start_test($sformatf("row %0d", r));
        @(posedge CLOCK_50);
        #DRIVE_DELAY;
        sw = rows[r].sw_value;
        host_frame_id = rows[r].host_id;
        write_done = rows[r].write_done;
        write_request = rows[r].write_request;
        read_request = rows[r].read_request;
        write_address = wr_addr;
        read_address = rd_addr;
        #SETTLE_DELAY;
        // combinational paths settle in the same cycle
        check_addr("sdram_address", sdram_address, rows[r].write_done ? rd_addr : wr_addr);
        check_bit("sdram_read_n", sdram_read_n, !(rows[r].read_request && rows[r].write_done));
        check_bit("sdram_write_n", sdram_write_n, !rows[r].write_request);
        check_bit("reader_reset", reader_reset, !rows[r].write_done);
        check_frame("static_frame_id", static_frame_id, rows[r].exp_frame_id);
        // letters lag write_done by one edge
        check_busy_letters(!prev_done);
        for (int k = 0; k < pulses; k++) begin
            @(posedge CLOCK_50);
            #DRIVE_DELAY;
            sequencing_trigger = (k < rows[r].seq_pulses);
            galvo_sequencing_trigger = (k < rows[r].galvo_pulses);
            #SETTLE_DELAY;
            // at least one trigger high in every pulse cycle
            check_bit("ledr8", ledr8, 1'b1);
            // letters already follow the new write_done level
            check_busy_letters(rows[r].exp_busy);
        end
        @(posedge CLOCK_50);
        #DRIVE_DELAY;
        sequencing_trigger = 1'b0;
        galvo_sequencing_trigger = 1'b0;
        #SETTLE_DELAY;
        check_bit("ledr8", ledr8, 1'b0);
        seq_total += rows[r].seq_pulses;
        galvo_total += rows[r].galvo_pulses;
        check_busy_letters(rows[r].exp_busy);
        exp_byte = expected_byte(rows[r].sw_value);
        check_segments("hex1", hex1, DIGIT_SEGMENTS[exp_byte[7:4]]);
        check_segments("hex0", hex0, DIGIT_SEGMENTS[exp_byte[3:0]]);
        prev_done = rows[r].write_done;
        finish_test();
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        void'($urandom(SEED));
        reset_key = 1'b1;
        write_done = 1'b0;
        write_request = 1'b0;
        read_request = 1'b0;
        write_address = '0;
        read_address = '0;
        sw = '0;
        host_frame_id = '0;
        sequencing_trigger = 1'b0;
        galvo_sequencing_trigger = 1'b0;
        // decoder values stay fixed for the whole run
        jtag_states = slm_pkg::jtag_state_t'($urandom());
        images_in_mem = slm_pkg::image_count_t'($urandom());
        display_cycles = slm_pkg::display_cycles_t'($urandom());
        galvo_positions = $urandom();
        fill_table();
        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        #DRIVE_DELAY;
        reset_key = 1'b0;
        check_reset_stages();
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(r);
        end
        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // worst case per row is far below 40 cycles
    initial begin
        #((NUM_ROWS * 40 + 100) * CLK_PERIOD);
        $display("watchdog: tests did not finish in time");
        $display("Regression failed");
        $finish;
    end

endmodule

//--- project.f
rtl/slm_pkg.sv
rtl/slm_reset_sequencer.sv
rtl/slm_sdram_access.sv
rtl/slm_panel_monitor.sv
rtl/slm_control_top.sv
verification/tb_slm_control_top.sv

//--- Makefile
# Verilator flow: lint the RTL top, build and run the testbench, clean
VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= tb_slm_control_top
RTL_TOP   ?= slm_control_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
FAIL_MSG  := Regression failed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
